// File: wb_soc_top.f
+incdir+design
design/soc_pkg.sv
design/line_ram.sv
design/wb_decoder.sv
design/wb_ram_slave.sv
design/wb_clint_slave.sv
design/wb_soc_top.sv
verif/wb_soc_assertions.sv
verif/tb_wb_soc.sv

// File: verif/tb_wb_soc.sv
// ================================================
// Testbench for the Wishbone memory fabric, acting
// as bus master against a reference RAM model
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module tb_wb_soc;
  import soc_pkg::*;

  localparam int          BURST_LEN  = `SOC_LINE_WORDS;
  localparam int          N_WRITES   = 40;
  // About 1000 cycles of tests, three times that as the limit
  localparam int          MAX_CYCLES = 3000;
  localparam logic [31:0] SEED       = 32'hada3;
  localparam int          WORD_BITS  = $clog2(`SOC_RAM_LINES * `SOC_LINE_WORDS);
  localparam logic [31:0] RAM_BASE   = `SOC_RAM_BASE;
  localparam logic [31:0] UNMAPPED   = 32'h5000_0000;
  // CLINT register addresses
  localparam logic [31:0] MSIP_ADR   = `SOC_CLINT_BASE | 32'(`SOC_CLINT_MSIP);
  localparam logic [31:0] CMP_LO     = `SOC_CLINT_BASE | 32'(`SOC_CLINT_MTIMECMP);
  localparam logic [31:0] CMP_HI     = `SOC_CLINT_BASE | 32'(`SOC_CLINT_MTIMECMP + 16'h4);
  localparam logic [31:0] MTIME_LO   = `SOC_CLINT_BASE | 32'(`SOC_CLINT_MTIME);

  logic        clk;
  logic        rst_n  = 1'b0;
  wb_req_t     wb_req = '0;
  wb_rsp_t     wb_rsp;
  logic        timer_irq;
  logic        sw_irq;
  logic [31:0] rng    = SEED;
  int          err_cnt = 0;
  int          cycles  = 0;
  // Reference RAM, one entry per 32-bit word
  logic [31:0] ref_mem [`SOC_RAM_LINES * `SOC_LINE_WORDS];

  wb_soc_top u_wb_soc_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int word_index(input logic [31:0] adr);
    return int'(adr[2 +: WORD_BITS]);
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      err_cnt++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  // ================================================
  // Bus master
  // ================================================
  // Request held until ack or err, sampled mid-cycle
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input wb_cti_e cti,
                            output logic [31:0] rdata, output logic got_err);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel, cti: cti};
    do begin
      @(negedge clk);
    end while (!(wb_rsp.ack || wb_rsp.err));
    rdata   = wb_rsp.dat;
    got_err = wb_rsp.err;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    wb_req <= '0;
  endtask

  // Gap between burst beats, cycle stays open
  task automatic bus_pause();
    @(posedge clk);
    wb_req.stb <= 1'b0;
  endtask

  task automatic ram_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] rdata;
    logic        got_err;
    bus_access(1'b1, adr, dat, sel, CTI_CLASSIC, rdata, got_err);
    bus_idle();
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        ref_mem[word_index(adr)][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
  endtask

  task automatic ram_read_check(input logic [31:0] adr);
    logic [31:0] rdata;
    logic        got_err;
    bus_access(1'b0, adr, '0, 4'hf, CTI_CLASSIC, rdata, got_err);
    bus_idle();
    check_word("RAM classic read", rdata, ref_mem[word_index(adr)]);
  endtask

  task automatic burst_read_check(input logic [31:0] base, input logic gap);
    logic [31:0] rdata;
    logic        got_err;
    wb_cti_e     cti;
    for (int w = 0; w < BURST_LEN; w++) begin
      cti = (w == BURST_LEN - 1) ? CTI_EOB : CTI_INCR;
      bus_access(1'b0, base + 32'(4 * w), '0, 4'hf, cti, rdata, got_err);
      check_word("RAM burst beat", rdata, ref_mem[word_index(base + 32'(4 * w))]);
      if (gap && (w < BURST_LEN - 1)) begin
        bus_pause();
      end
    end
    bus_idle();
  endtask

  task automatic clint_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdata);
    logic got_err;
    bus_access(we, adr, dat, 4'hf, CTI_CLASSIC, rdata, got_err);
    bus_idle();
  endtask

  // ================================================
  // Test sequence
  // ================================================
  initial begin
    logic [31:0] addrs [N_WRITES];
    logic [31:0] rdata;
    logic [31:0] base;
    logic [31:0] t0;
    logic [31:0] t1;
    logic        got_err;
    int          waited;
    int          prot_cnt;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("interrupts low after reset", !timer_irq && !sw_irq);

    // Full word first so every byte is defined, then a strobed write
    for (int i = 0; i < N_WRITES; i++) begin
      rng      = xorshift32(rng);
      addrs[i] = RAM_BASE | (rng & 32'h0000_0ffc);
      rng      = xorshift32(rng);
      ram_write(addrs[i], rng, 4'hf);
      rng      = xorshift32(rng);
      t0       = rng;
      rng      = xorshift32(rng);
      ram_write(addrs[i], t0, rng[3:0]);
    end
    for (int i = 0; i < N_WRITES; i++) begin
      ram_read_check(addrs[i]);
    end

    // Three line bursts, the last with gaps between beats
    for (int b = 0; b < 3; b++) begin
      rng  = xorshift32(rng);
      base = RAM_BASE | (rng & 32'h0000_0ff0);
      for (int w = 0; w < BURST_LEN; w++) begin
        rng = xorshift32(rng);
        ram_write(base + 32'(4 * w), rng, 4'hf);
      end
      burst_read_check(base, b == 2);
    end

    // Unmapped region
    bus_access(1'b1, UNMAPPED, 32'hdead_beef, 4'hf, CTI_CLASSIC, rdata, got_err);
    bus_idle();
    check_flag("unmapped write did not return err", got_err);
    bus_access(1'b0, UNMAPPED, '0, 4'hf, CTI_CLASSIC, rdata, got_err);
    bus_idle();
    check_flag("unmapped read did not return err", got_err);
    check_word("unmapped read data", rdata, '0);
    ram_read_check(addrs[0]);

    // CLINT timer and software interrupt
    clint_access(1'b0, MTIME_LO, '0, t0);
    clint_access(1'b0, MTIME_LO, '0, t1);
    check_flag("mtime did not advance between reads", t1 > t0);
    clint_access(1'b0, MTIME_LO, '0, t0);
    clint_access(1'b1, CMP_LO, t0 + 32'd60, rdata);
    clint_access(1'b1, CMP_HI, 32'd0, rdata);
    @(negedge clk);
    check_flag("timer irq high before mtimecmp reached", !timer_irq);
    waited = 0;
    while (!timer_irq && (waited < 200)) begin
      @(negedge clk);
      waited++;
    end
    check_flag("timer irq not raised within 200 cycles", timer_irq);
    clint_access(1'b1, MSIP_ADR, 32'd1, rdata);
    @(negedge clk);
    check_flag("sw irq not raised by msip write", sw_irq);
    clint_access(1'b1, MSIP_ADR, 32'd0, rdata);
    @(negedge clk);
    check_flag("sw irq not cleared by msip write", !sw_irq);

    prot_cnt = int'(u_wb_soc_top.u_wb_soc_assertions.fail_count);
    $display("Error counts: %0d data, %0d protocol", err_cnt, prot_cnt);
    if ((err_cnt == 0) && (prot_cnt == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verif/wb_soc_assertions.sv
// ================================================
// Bus protocol and RAM timing checks on the fabric
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module wb_soc_assertions (
  input logic                clk_i,
  input logic                rst_ni,
  input soc_pkg::wb_req_t    wb_req_i,
  input soc_pkg::wb_rsp_t    wb_rsp_i,
  input soc_pkg::wb_req_t    ram_req_i,
  input soc_pkg::wb_rsp_t    ram_rsp_i,
  input soc_pkg::ram_state_e ram_state_i
);
  import soc_pkg::*;

  localparam logic [31:0] RAM_BASE   = `SOC_RAM_BASE;
  localparam logic [31:0] CLINT_BASE = `SOC_CLINT_BASE;

  // Failed properties so far
  int unsigned fail_count = 0;

  logic ram_req;
  logic unmapped;
  // Read burst open on the RAM bus, seen from the handshake alone
  logic burst_q;

  assign ram_req  = ram_req_i.cyc && ram_req_i.stb;
  assign unmapped = wb_req_i.cyc && wb_req_i.stb &&
                    (wb_req_i.adr[31:28] != RAM_BASE[31:28]) &&
                    (wb_req_i.adr[31:28] != CLINT_BASE[31:28]);

  // Opened by an acked incrementing read beat
  // Closed by the last beat or when cyc drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      burst_q <= 1'b0;
    end else if (!ram_req_i.cyc) begin
      burst_q <= 1'b0;
    end else if (ram_req && !ram_req_i.we && ram_rsp_i.ack) begin
      burst_q <= (ram_req_i.cti == CTI_INCR);
    end
  end

  // ================================================
  // RAM timing
  // ================================================
  a_write_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ram_req && ram_req_i.we && !burst_q) |-> ram_rsp_i.ack)
    else begin
      fail_count++;
      $error("RAM write not acknowledged in the cycle it was presented");
    end

  // First ack exactly the latency after the first cycle
  a_read_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ram_req && !ram_req_i.we && (ram_state_i == RAM_IDLE)) |->
      (!ram_rsp_i.ack)[*`SOC_RAM_LATENCY] ##1 ram_rsp_i.ack)
    else begin
      fail_count++;
      $error("RAM read first ack not at the fixed latency");
    end

  // Later beats of an open burst ack at once
  a_burst_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ram_req && !ram_req_i.we && burst_q) |-> ram_rsp_i.ack)
    else begin
      fail_count++;
      $error("RAM burst beat not acknowledged in the cycle it was presented");
    end

  // ================================================
  // Handshake
  // ================================================
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else begin
      fail_count++;
      $error("ack and err high together");
    end

  a_rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_rsp_i.ack || wb_rsp_i.err) |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
      fail_count++;
      $error("Response seen without cyc and stb");
    end

  a_unmapped_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    unmapped |-> (wb_rsp_i.err && !wb_rsp_i.ack))
    else begin
      fail_count++;
      $error("Unmapped access did not get err alone");
    end

endmodule

bind wb_soc_top wb_soc_assertions u_wb_soc_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .wb_req_i    (wb_req_i),
  .wb_rsp_i    (wb_rsp_o),
  .ram_req_i   (ram_req),
  .ram_rsp_i   (ram_rsp),
  .ram_state_i (u_wb_ram_slave.state_q)
);

// File: design/wb_soc_top.sv
// ================================================
// Wishbone memory fabric, decoder with RAM and
// CLINT slaves side by side
// ================================================
`timescale 1ns/100ps

module wb_soc_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  // External bus master
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  // CLINT interrupts
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  // Decoder to slave buses
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t clint_req;
  wb_rsp_t clint_rsp;

  // ================================================
  // Address decoder
  // ================================================
  wb_decoder u_wb_decoder (
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .ram_req_o   (ram_req),
    .ram_rsp_i   (ram_rsp),
    .clint_req_o (clint_req),
    .clint_rsp_i (clint_rsp)
  );

  // ================================================
  // Main RAM at 0x8000_0000
  // ================================================
  wb_ram_slave u_wb_ram_slave (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (ram_req),
    .wb_rsp_o (ram_rsp)
  );

  // ================================================
  // CLINT at 0x3000_0000
  // ================================================
  wb_clint_slave u_wb_clint_slave (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_i    (clint_req),
    .wb_rsp_o    (clint_rsp),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

endmodule

// File: design/wb_clint_slave.sv
// ================================================
// CLINT slave, mtime and mtimecmp timer plus msip
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module wb_clint_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);
  import soc_pkg::*;

  // Register offsets, high halves at +4
  localparam logic [15:0] OFF_MSIP   = `SOC_CLINT_MSIP;
  localparam logic [15:0] OFF_CMP_LO = `SOC_CLINT_MTIMECMP;
  localparam logic [15:0] OFF_CMP_HI = `SOC_CLINT_MTIMECMP + 16'h4;
  localparam logic [15:0] OFF_MT_LO  = `SOC_CLINT_MTIME;
  localparam logic [15:0] OFF_MT_HI  = `SOC_CLINT_MTIME + 16'h4;

  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;
  logic        msip_q;
  logic        msip_d;
  logic        req;
  logic        wr;
  logic [15:0] offs;
  logic [31:0] rdata;

  // Byte-lane merge of a write into a 32-bit half
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_i,
                                              input logic [31:0] new_i,
                                              input logic [3:0]  sel_i);
    logic [31:0] res;
    res = old_i;
    for (int b = 0; b < 4; b++) begin
      if (sel_i[b]) begin
        res[b*8 +: 8] = new_i[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign req  = wb_req_i.cyc && wb_req_i.stb;
  assign wr   = req && wb_req_i.we;
  // Low bits only
  assign offs = wb_req_i.adr[15:0];

  // ================================================
  // Read mux
  // ================================================
  always_comb begin
    case (offs)
      OFF_MSIP:   rdata = {31'b0, msip_q};
      OFF_CMP_LO: rdata = mtimecmp_q[31:0];
      OFF_CMP_HI: rdata = mtimecmp_q[63:32];
      OFF_MT_LO:  rdata = mtime_q[31:0];
      OFF_MT_HI:  rdata = mtime_q[63:32];
      default:    rdata = '0;
    endcase
  end

  // ================================================
  // Register update
  // ================================================
  always_comb begin
    // Free-running count unless software writes it
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr) begin
      case (offs)
        OFF_MSIP: begin
          if (wb_req_i.sel[0]) begin
            msip_d = wb_req_i.dat[0];
          end
        end
        OFF_CMP_LO: begin
          mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], wb_req_i.dat, wb_req_i.sel);
        end
        OFF_CMP_HI: begin
          mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], wb_req_i.dat, wb_req_i.sel);
        end
        // Written half replaces the count, other half held
        OFF_MT_LO: begin
          mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], wb_req_i.dat, wb_req_i.sel)};
        end
        OFF_MT_HI: begin
          mtime_d = {merge_bytes(mtime_q[63:32], wb_req_i.dat, wb_req_i.sel), mtime_q[31:0]};
        end
        default: begin
          // Unused offsets ignore writes
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      msip_q     <= msip_d;
    end
  end

  // Zero-wait response
  assign wb_rsp_o.dat = rdata;
  assign wb_rsp_o.ack = req;
  assign wb_rsp_o.err = 1'b0;

  // Level interrupts
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

// File: design/wb_ram_slave.sv
// ================================================
// Wishbone slave for the line RAM, fixed read
// latency and a line buffer for incrementing bursts
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module wb_ram_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o
);
  import soc_pkg::*;

  // Line and address geometry
  localparam int LINE_W = `SOC_LINE_WORDS * 32;
  localparam int LINE_B = `SOC_LINE_WORDS * 4;
  localparam int OFFS_W = $clog2(LINE_B);
  localparam int WSEL_W = $clog2(`SOC_LINE_WORDS);
  localparam int IDX_W  = $clog2(`SOC_RAM_LINES);

  // Latency counter, 1 in the first wait cycle
  localparam int                CNT_W    = $clog2(`SOC_RAM_LATENCY + 1);
  localparam logic [CNT_W-1:0]  CNT_DONE = CNT_W'(`SOC_RAM_LATENCY);
  localparam logic [CNT_W-1:0]  CNT_LOAD = CNT_W'(1);

  ram_state_e        state_q;
  ram_state_e        state_d;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_d;

  // Burst line buffer
  logic [LINE_W-1:0] line_q;

  // Array side
  logic [IDX_W-1:0]  ram_addr;
  logic [LINE_W-1:0] ram_wdata;
  logic [LINE_B-1:0] ram_wstrb;
  logic [LINE_W-1:0] ram_rdata;

  logic [WSEL_W-1:0] word_sel;
  logic              req;
  logic              wr_go;
  logic              rd_go;
  logic              capture;
  logic              ack;

  // ================================================
  // Request decode
  // ================================================
  assign req      = wb_req_i.cyc && wb_req_i.stb;
  assign ram_addr = wb_req_i.adr[OFFS_W +: IDX_W];
  assign word_sel = wb_req_i.adr[2 +: WSEL_W];

  // Accesses start only from idle
  assign wr_go = req && wb_req_i.we && (state_q == RAM_IDLE);
  assign rd_go = req && !wb_req_i.we && (state_q == RAM_IDLE);

  // Word copied into every lane
  // Strobes moved to the addressed word
  assign ram_wdata = {`SOC_LINE_WORDS{wb_req_i.dat}};
  assign ram_wstrb = wr_go ? (LINE_B'(wb_req_i.sel) << (word_sel * 4)) : '0;

  // Array output is valid in the first wait cycle
  assign capture = (state_q == RAM_WAIT) && (cnt_q == CNT_LOAD);

  line_ram u_line_ram (
    .clk_i   (clk_i),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .wstrb_i (ram_wstrb),
    .rd_en_i (rd_go),
    .rdata_o (ram_rdata)
  );

  // ================================================
  // Read FSM
  // ================================================
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    ack     = 1'b0;
    case (state_q)
      RAM_IDLE: begin
        if (wr_go) begin
          // Word write, array updates at the next edge
          ack = 1'b1;
        end else if (rd_go) begin
          state_d = RAM_WAIT;
          cnt_d   = CNT_LOAD;
        end
      end
      RAM_WAIT: begin
        if (!wb_req_i.cyc) begin
          // Master gave up the cycle
          state_d = RAM_IDLE;
        end else if (cnt_q != CNT_DONE) begin
          cnt_d = cnt_q + 1'b1;
        end else if (req) begin
          ack = 1'b1;
          // Stay on the buffered line for more beats
          if (wb_req_i.cti == CTI_INCR) begin
            state_d = RAM_BURST;
          end else begin
            state_d = RAM_IDLE;
          end
        end
      end
      RAM_BURST: begin
        if (!wb_req_i.cyc) begin
          state_d = RAM_IDLE;
        end else if (req && !wb_req_i.we) begin
          // Served from the buffer, stb low just waits
          ack = 1'b1;
          if (wb_req_i.cti != CTI_INCR) begin
            state_d = RAM_IDLE;
          end
        end
      end
      default: begin
        state_d = RAM_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RAM_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Line capture, one array read per access or burst
  always_ff @(posedge clk_i) begin
    if (capture) begin
      line_q <= ram_rdata;
    end
  end

  // ================================================
  // Response
  // ================================================
  assign wb_rsp_o.dat = line_q[word_sel*32 +: 32];
  assign wb_rsp_o.ack = ack;
  assign wb_rsp_o.err = 1'b0;

endmodule

// File: design/wb_decoder.sv
// ================================================
// Wishbone address decoder with response combining
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module wb_decoder (
  // Bus master side
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  // Main RAM slave
  output soc_pkg::wb_req_t ram_req_o,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  // CLINT slave
  output soc_pkg::wb_req_t clint_req_o,
  input  soc_pkg::wb_rsp_t clint_rsp_i
);
  import soc_pkg::*;

  // Region bases, only the top nibble is compared
  localparam logic [31:0] RAM_BASE   = `SOC_RAM_BASE;
  localparam logic [31:0] CLINT_BASE = `SOC_CLINT_BASE;

  slave_sel_e sel;

  // ================================================
  // Region classification
  // ================================================
  always_comb begin
    if (wb_req_i.adr[31:28] == RAM_BASE[31:28]) begin
      sel = SEL_RAM;
    end else if (wb_req_i.adr[31:28] == CLINT_BASE[31:28]) begin
      sel = SEL_CLINT;
    end else begin
      sel = SEL_NONE;
    end
  end

  // ================================================
  // Request routing
  // ================================================
  // Payload goes to both slaves
  // Handshake only to the selected one
  always_comb begin
    ram_req_o       = wb_req_i;
    ram_req_o.cyc   = wb_req_i.cyc && (sel == SEL_RAM);
    ram_req_o.stb   = wb_req_i.stb && (sel == SEL_RAM);

    clint_req_o     = wb_req_i;
    clint_req_o.cyc = wb_req_i.cyc && (sel == SEL_CLINT);
    clint_req_o.stb = wb_req_i.stb && (sel == SEL_CLINT);
  end

  // ================================================
  // Response combining
  // ================================================
  always_comb begin
    wb_rsp_o = '0;
    case (sel)
      SEL_RAM: begin
        wb_rsp_o = ram_rsp_i;
      end
      SEL_CLINT: begin
        wb_rsp_o = clint_rsp_i;
      end
      default: begin
        // Unmapped, error in the same cycle
        // Data stays zero
        wb_rsp_o.err = wb_req_i.cyc && wb_req_i.stb;
      end
    endcase
  end

endmodule

// File: design/line_ram.sv
// ================================================
// Cache-line-wide RAM, byte-strobed write port
// and one-cycle registered read
// ================================================
`timescale 1ns/100ps
`include "soc_params.svh"

module line_ram (
  input  logic                              clk_i,
  // Line index
  input  logic [$clog2(`SOC_RAM_LINES)-1:0] addr_i,
  // Write side
  input  logic [`SOC_LINE_WORDS*32-1:0]     wdata_i,
  input  logic [`SOC_LINE_WORDS*4-1:0]      wstrb_i,
  // Read side
  input  logic                              rd_en_i,
  output logic [`SOC_LINE_WORDS*32-1:0]     rdata_o
);

  // Line geometry
  localparam int LINE_W     = `SOC_LINE_WORDS * 32;
  localparam int LINE_BYTES = `SOC_LINE_WORDS * 4;

  // Storage array
  logic [LINE_W-1:0] mem_q [`SOC_RAM_LINES];

  // ================================================
  // Write port
  // ================================================
  // One enable per byte lane
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (wstrb_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // ================================================
  // Read port
  // ================================================
  // Output holds the last line read until the next rd_en_i
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: design/soc_pkg.sv
// ================================================
// Shared Wishbone bus types and FSM encodings
// ================================================
package soc_pkg;

  // ================================================
  // Wishbone B4 bus
  // ================================================

  // Cycle type identifier, B4 encoding
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    wb_cti_e     cti;
  } wb_req_t;

  // Slave to master, rty and stall not used
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

  // ================================================
  // Decoder and slave encodings
  // ================================================

  // Target of the current access
  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_CLINT,
    SEL_NONE
  } slave_sel_e;

  // RAM slave read sequencing
  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_BURST
  } ram_state_e;

endpackage

// File: design/soc_params.svh
// ================================================
// SoC memory map, RAM geometry and RAM timing
// ================================================
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ================================================
// Memory map, regions matched on adr[31:28]
// ================================================
`define SOC_RAM_BASE    32'h8000_0000
`define SOC_CLINT_BASE  32'h3000_0000

// ================================================
// Main RAM
// ================================================
// 32-bit words per cache line (16 bytes)
`define SOC_LINE_WORDS  4
// Lines in the array, 4 KB in total
`define SOC_RAM_LINES   256
// Cycles from an accepted read to its first ack
`define SOC_RAM_LATENCY 4

// ================================================
// CLINT register offsets (low word, high word at +4)
// ================================================
`define SOC_CLINT_MSIP     16'h0000
`define SOC_CLINT_MTIMECMP 16'h4000
`define SOC_CLINT_MTIME    16'hBFF8

`endif
